/* src/bam_pkg.sv */
package bam_pkg;

  // ----------------------------------------
  // widths that carry a meaning
  // ----------------------------------------

  // avalon word address, passed through unaligned
  typedef logic [31:0] addr_t;

  // burst length, legal values 1 to 8
  typedef logic [3:0]  burst_t;

  // number of low address bits a command may use
  typedef logic [4:0]  win_t;

  // apb side
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] reg_t;

  // ----------------------------------------
  // command controller states
  // ----------------------------------------
  typedef enum logic [1:0] {
    CMD_IDLE = 2'b00,
    CMD_POP  = 2'b01,
    CMD_WR   = 2'b10,
    CMD_RD   = 2'b11
  } cmd_state_t;

  // ----------------------------------------
  // register map
  // ----------------------------------------
  localparam apb_addr_t REG_CTRL     = 8'h00;
  localparam apb_addr_t REG_WINDOW   = 8'h04;
  localparam apb_addr_t REG_BLOCKED  = 8'h08;
  localparam apb_addr_t REG_CPL_USED = 8'h0C;

  // 64k words open after reset
  localparam win_t WINDOW_RESET = 5'd16;

endpackage

/* src/bam_csr.sv */
`timescale 1ns/1ps

module bam_csr import bam_pkg::*; #(
  parameter int CPL_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         srst_reg,

  // apb configuration port
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  apb_addr_t                    paddr_i,
  input  reg_t                         pwdata_i,
  output reg_t                         prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,

  // status from the datapath
  input  logic                         blocked_pulse_i,
  input  logic [$clog2(CPL_DEPTH):0]   cpl_used_i,

  // configuration to the command controller
  output logic                         enable_o,
  output win_t                         window_o
);

  logic apb_access;
  logic apb_write;
  logic known_addr;
  logic enable_q;
  win_t window_q;
  reg_t blocked_cnt;

  // no wait states, every access phase completes
  assign apb_access = psel_i & penable_i;
  assign apb_write  = apb_access & pwrite_i;
  assign pready_o   = apb_access;

  // ----------------------------------------
  // read mux and address decode
  // ----------------------------------------
  always_comb begin
    prdata_o   = '0;
    known_addr = 1'b1;
    case (paddr_i)
      REG_CTRL:     prdata_o = reg_t'(enable_q);
      REG_WINDOW:   prdata_o = reg_t'(window_q);
      REG_BLOCKED:  prdata_o = blocked_cnt;
      REG_CPL_USED: prdata_o = reg_t'(cpl_used_i);
      default:      known_addr = 1'b0;
    endcase
  end

  assign pslverr_o = apb_access & ~known_addr;

  // ----------------------------------------
  // writable registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      enable_q <= 1'b0;
      window_q <= WINDOW_RESET;
    end else if (apb_write) begin
      case (paddr_i)
        REG_CTRL:   enable_q <= pwdata_i[0];
        REG_WINDOW: window_q <= pwdata_i[4:0];
        default: ;
      endcase
    end
  end

  // blocked command count, any write to the register clears it
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      blocked_cnt <= '0;
    end else if (apb_write && (paddr_i == REG_BLOCKED)) begin
      blocked_cnt <= '0;
    end else if (blocked_pulse_i) begin
      blocked_cnt <= blocked_cnt + 1'b1;
    end
  end

  assign enable_o = enable_q;
  assign window_o = window_q;

endmodule

/* src/bam_cmd_ctrl.sv */
`timescale 1ns/1ps

module bam_cmd_ctrl import bam_pkg::*; #(
  parameter int DATA_W    = 64,
  parameter int CPL_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         srst_reg,

  // configuration and credit
  input  logic                         enable_i,
  input  win_t                         window_i,
  input  logic [$clog2(CPL_DEPTH):0]   cpl_free_i,

  // command fifo, show-ahead
  input  logic                         cmd_empty_i,
  input  logic                         cmd_is_wr_i,
  input  addr_t                        cmd_addr_i,
  input  burst_t                       cmd_burst_i,
  input  logic [DATA_W/8-1:0]          cmd_be_i,
  output logic                         cmd_rreq_o,

  // write data fifo, show-ahead
  input  logic [DATA_W-1:0]            wdata_i,
  input  logic [DATA_W/8-1:0]          wbe_i,
  output logic                         wdata_rreq_o,

  // avalon request side
  output logic                         avm_write_o,
  output logic                         avm_read_o,
  output addr_t                        avm_address_o,
  output logic [DATA_W-1:0]            avm_writedata_o,
  output logic [DATA_W/8-1:0]          avm_byteenable_o,
  output burst_t                       avm_burstcount_o,
  input  logic                         avm_waitrequest_i,

  // status and read reservation
  output logic                         blocked_pulse_o,
  output logic                         rd_issue_o,
  output burst_t                       rd_burst_o,
  output logic                         rd_blocked_o
);

  localparam int BE_W = DATA_W / 8;

  cmd_state_t          state_q;
  cmd_state_t          state_d;
  burst_t              beat_cnt;
  logic                credit_ok;
  logic                cmd_start;
  logic                out_of_win;

  // command fields latched at pop
  addr_t               addr_q;
  burst_t              burst_q;
  logic [BE_W-1:0]     be_q;
  logic                blocked_q;

  // ----------------------------------------
  // start condition
  // ----------------------------------------
  // writes need no credit, reads need room for the whole burst
  assign credit_ok = cmd_is_wr_i | (32'(cpl_free_i) >= 32'(cmd_burst_i));
  assign cmd_start = enable_i & ~cmd_empty_i & ~avm_waitrequest_i & credit_ok;

  // any address bit at or above the window blocks the command
  assign out_of_win = |(cmd_addr_i >> window_i);

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      CMD_IDLE: begin
        if (cmd_start) begin
          state_d = CMD_POP;
        end
      end
      // head is still valid here, so the type comes straight from the fifo
      CMD_POP:  state_d = cmd_is_wr_i ? CMD_WR : CMD_RD;
      CMD_WR: begin
        if (beat_cnt == burst_t'(1)) begin
          state_d = CMD_IDLE;
        end
      end
      CMD_RD:   state_d = CMD_IDLE;
      default:  state_d = CMD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      state_q  <= CMD_IDLE;
      beat_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == CMD_POP) begin
        beat_cnt <= cmd_burst_i;
      end else if (state_q == CMD_WR) begin
        beat_cnt <= beat_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == CMD_POP) begin
      addr_q    <= cmd_addr_i;
      burst_q   <= cmd_burst_i;
      be_q      <= cmd_be_i;
      blocked_q <= out_of_win;
    end
  end

  assign cmd_rreq_o      = (state_q == CMD_POP);
  assign wdata_rreq_o    = (state_q == CMD_WR);
  assign blocked_pulse_o = (state_q == CMD_POP) & out_of_win;

  // credit is reserved while in CMD_RD, before the next start check
  assign rd_issue_o   = (state_q == CMD_RD);
  assign rd_burst_o   = burst_q;
  assign rd_blocked_o = blocked_q;

  // ----------------------------------------
  // registered avalon request
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      avm_write_o <= 1'b0;
      avm_read_o  <= 1'b0;
    end else begin
      avm_write_o <= (state_q == CMD_WR) & ~blocked_q;
      avm_read_o  <= (state_q == CMD_RD) & ~blocked_q;
    end
  end

  always_ff @(posedge clk) begin
    avm_address_o    <= addr_q;
    avm_burstcount_o <= burst_q;
    avm_writedata_o  <= wdata_i;
    // reads carry the command byte enables, writes the per-beat ones
    avm_byteenable_o <= (state_q == CMD_RD) ? be_q : wbe_i;
  end

endmodule

/* src/bam_cpl_buffer.sv */
`timescale 1ns/1ps

module bam_cpl_buffer import bam_pkg::*; #(
  parameter int DATA_W    = 64,
  parameter int CPL_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         srst_reg,

  // read reservation from the command controller
  input  logic                         rd_issue_i,
  input  burst_t                       rd_burst_i,
  input  logic                         rd_blocked_i,

  // avalon read return
  input  logic [DATA_W-1:0]            avm_readdata_i,
  input  logic                         avm_readdatavalid_i,
  input  logic [1:0]                   avm_response_i,

  // completion port
  input  logic                         cpl_rdreq_i,
  output logic [DATA_W-1:0]            cpl_rdata_o,
  output logic                         cpl_err_o,
  output logic                         cpl_valid_o,

  // credit level
  output logic [$clog2(CPL_DEPTH):0]   cpl_free_o,
  output logic [$clog2(CPL_DEPTH):0]   cpl_used_o
);

  localparam int PTR_W = $clog2(CPL_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // entry is {err, data}
  logic [DATA_W:0]     mem [CPL_DEPTH];
  logic [DATA_W:0]     wr_entry;
  logic [DATA_W:0]     rd_entry_q;
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;

  logic                rdv_q;
  logic [DATA_W-1:0]   rdata_q;
  logic                rerr_q;

  logic [CNT_W-1:0]    blk_pending;
  logic [CNT_W-1:0]    used_q;
  logic                fill_en;
  logic                wr_en;

  // ----------------------------------------
  // read return stage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      rdv_q <= 1'b0;
    end else begin
      rdv_q <= avm_readdatavalid_i;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= avm_readdata_i;
    rerr_q  <= |avm_response_i;
  end

  // blocked reads fill error words in gaps of slave data
  assign fill_en  = ~rdv_q & (blk_pending != '0);
  assign wr_en    = rdv_q | fill_en;
  assign wr_entry = rdv_q ? {rerr_q, rdata_q} : {1'b1, {DATA_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      blk_pending <= '0;
    end else begin
      blk_pending <= blk_pending
                   + ((rd_issue_i && rd_blocked_i) ? CNT_W'(rd_burst_i) : CNT_W'(0))
                   - (fill_en ? CNT_W'(1) : CNT_W'(0));
    end
  end

  // ----------------------------------------
  // memory and pointers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_entry;
    end
    if (cpl_rdreq_i) begin
      rd_entry_q <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (cpl_rdreq_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign cpl_valid_o = wr_en;
  assign cpl_rdata_o = rd_entry_q[DATA_W-1:0];
  assign cpl_err_o   = rd_entry_q[DATA_W];

  // credits held from reservation until the consumer reads the entry
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      used_q <= '0;
    end else begin
      used_q <= used_q
              + (rd_issue_i ? CNT_W'(rd_burst_i) : CNT_W'(0))
              - (cpl_rdreq_i ? CNT_W'(1) : CNT_W'(0));
    end
  end

  assign cpl_used_o = used_q;
  assign cpl_free_o = CNT_W'(CPL_DEPTH) - used_q;

endmodule

/* src/bam_top.sv */
`timescale 1ns/1ps

module bam_top import bam_pkg::*; #(
  parameter int DATA_W    = 64,
  parameter int CPL_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  srst_reg,

  // apb configuration
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  apb_addr_t             paddr_i,
  input  reg_t                  pwdata_i,
  output reg_t                  prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,

  // command fifo
  input  logic                  cmd_empty_i,
  input  logic                  cmd_is_wr_i,
  input  addr_t                 cmd_addr_i,
  input  burst_t                cmd_burst_i,
  input  logic [DATA_W/8-1:0]   cmd_be_i,
  output logic                  cmd_rreq_o,

  // write data fifo
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [DATA_W/8-1:0]   wbe_i,
  output logic                  wdata_rreq_o,

  // avalon master
  output logic                  avm_write_o,
  output logic                  avm_read_o,
  output addr_t                 avm_address_o,
  output logic [DATA_W-1:0]     avm_writedata_o,
  output logic [DATA_W/8-1:0]   avm_byteenable_o,
  output burst_t                avm_burstcount_o,
  input  logic                  avm_waitrequest_i,
  input  logic [DATA_W-1:0]     avm_readdata_i,
  input  logic                  avm_readdatavalid_i,
  input  logic [1:0]            avm_response_i,

  // completion port
  input  logic                  cpl_rdreq_i,
  output logic [DATA_W-1:0]     cpl_rdata_o,
  output logic                  cpl_err_o,
  output logic                  cpl_valid_o
);

  localparam int CNT_W = $clog2(CPL_DEPTH) + 1;

  // ----------------------------------------
  // internal wires
  // ----------------------------------------
  logic              enable;
  win_t              window;
  logic              blocked_pulse;
  logic              rd_issue;
  burst_t            rd_burst;
  logic              rd_blocked;
  logic [CNT_W-1:0]  cpl_free;
  logic [CNT_W-1:0]  cpl_used;

  bam_csr #(
    .CPL_DEPTH (CPL_DEPTH)
  ) u_csr (
    .clk             (clk),
    .srst_reg        (srst_reg),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .blocked_pulse_i (blocked_pulse),
    .cpl_used_i      (cpl_used),
    .enable_o        (enable),
    .window_o        (window)
  );

  bam_cmd_ctrl #(
    .DATA_W    (DATA_W),
    .CPL_DEPTH (CPL_DEPTH)
  ) u_cmd_ctrl (
    .clk               (clk),
    .srst_reg          (srst_reg),
    .enable_i          (enable),
    .window_i          (window),
    .cpl_free_i        (cpl_free),
    .cmd_empty_i       (cmd_empty_i),
    .cmd_is_wr_i       (cmd_is_wr_i),
    .cmd_addr_i        (cmd_addr_i),
    .cmd_burst_i       (cmd_burst_i),
    .cmd_be_i          (cmd_be_i),
    .cmd_rreq_o        (cmd_rreq_o),
    .wdata_i           (wdata_i),
    .wbe_i             (wbe_i),
    .wdata_rreq_o      (wdata_rreq_o),
    .avm_write_o       (avm_write_o),
    .avm_read_o        (avm_read_o),
    .avm_address_o     (avm_address_o),
    .avm_writedata_o   (avm_writedata_o),
    .avm_byteenable_o  (avm_byteenable_o),
    .avm_burstcount_o  (avm_burstcount_o),
    .avm_waitrequest_i (avm_waitrequest_i),
    .blocked_pulse_o   (blocked_pulse),
    .rd_issue_o        (rd_issue),
    .rd_burst_o        (rd_burst),
    .rd_blocked_o      (rd_blocked)
  );

  bam_cpl_buffer #(
    .DATA_W    (DATA_W),
    .CPL_DEPTH (CPL_DEPTH)
  ) u_cpl_buffer (
    .clk                 (clk),
    .srst_reg            (srst_reg),
    .rd_issue_i          (rd_issue),
    .rd_burst_i          (rd_burst),
    .rd_blocked_i        (rd_blocked),
    .avm_readdata_i      (avm_readdata_i),
    .avm_readdatavalid_i (avm_readdatavalid_i),
    .avm_response_i      (avm_response_i),
    .cpl_rdreq_i         (cpl_rdreq_i),
    .cpl_rdata_o         (cpl_rdata_o),
    .cpl_err_o           (cpl_err_o),
    .cpl_valid_o         (cpl_valid_o),
    .cpl_free_o          (cpl_free),
    .cpl_used_o          (cpl_used)
  );

endmodule

/* test/bam_assertions.sv */
`timescale 1ns/1ps

module bam_assertions (
  input logic clk,
  input logic srst_reg,
  input logic cmd_rreq_o,
  input logic wdata_rreq_o,
  input logic avm_write_o,
  input logic avm_read_o,
  input logic enable
);

  // the two fifo pops belong to different states
  a_pop_excl: assert property (@(posedge clk) disable iff (srst_reg)
    !(cmd_rreq_o && wdata_rreq_o))
    else $error("command and write data pops high together");

  a_strobe_excl: assert property (@(posedge clk) disable iff (srst_reg)
    !(avm_write_o && avm_read_o))
    else $error("avalon write and read high together");

  // nothing leaves the fifos while disabled
  a_enable: assert property (@(posedge clk) disable iff (srst_reg)
    !enable |-> !(cmd_rreq_o || wdata_rreq_o))
    else $error("fifo request while enable is low");

endmodule

bind bam_top bam_assertions u_assertions (
  .clk          (clk),
  .srst_reg     (srst_reg),
  .cmd_rreq_o   (cmd_rreq_o),
  .wdata_rreq_o (wdata_rreq_o),
  .avm_write_o  (avm_write_o),
  .avm_read_o   (avm_read_o),
  .enable       (enable)
);

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top import bam_pkg::*;;

  localparam int DATA_W    = 64;
  localparam int CPL_DEPTH = 16;
  localparam int BE_W      = DATA_W / 8;
  localparam int MAX_CYC   = 20000;

  logic clk = 1'b0;
  logic srst_reg;
  logic psel_i, penable_i, pwrite_i;
  apb_addr_t paddr_i;
  reg_t pwdata_i, prdata_o;
  logic pready_o, pslverr_o;
  logic cmd_empty_i, cmd_is_wr_i, cmd_rreq_o;
  addr_t cmd_addr_i, avm_address_o;
  burst_t cmd_burst_i, avm_burstcount_o;
  logic [BE_W-1:0] cmd_be_i, wbe_i, avm_byteenable_o;
  logic [DATA_W-1:0] wdata_i, avm_writedata_o, avm_readdata_i, cpl_rdata_o;
  logic wdata_rreq_o, avm_write_o, avm_read_o, avm_waitrequest_i, avm_readdatavalid_i;
  logic [1:0] avm_response_i;
  logic cpl_rdreq_i, cpl_err_o, cpl_valid_o;

  // ----------------------------------------
  // model state
  // ----------------------------------------
  integer seed = 32'h2526433b;
  int cyc = 0, errors = 0, checks = 0, pop_cnt = 0;
  int win = 16, blocked_model = 0, used_model = 0, blk_exp = 0;
  int stored = 0, sl_left = 0, sl_idx = 0, test_errs = 0;
  logic drain = 1'b1, chk_pend = 1'b0, sl_err = 1'b0;
  addr_t sl_addr;

  // command and write data fifos
  bit cq_wr[$];
  addr_t cq_addr[$];
  burst_t cq_burst[$];
  logic [BE_W-1:0] cq_be[$];
  logic [DATA_W-1:0] wq_data[$];
  logic [BE_W-1:0] wq_be[$];
  // expected avalon requests
  addr_t ew_addr[$], er_addr[$];
  burst_t ew_burst[$], er_burst[$];
  logic [DATA_W-1:0] ew_data[$];
  logic [BE_W-1:0] ew_be[$], er_be[$];
  int ew_idx[$];
  // slave pending reads and reference completions
  addr_t sp_addr[$];
  burst_t sp_burst[$];
  int sp_due[$];
  logic [DATA_W-1:0] rc_data[$];
  logic rc_err[$];
  logic [DATA_W-1:0] slv_mem [addr_t];

  bam_top #(.DATA_W(DATA_W), .CPL_DEPTH(CPL_DEPTH)) u_dut (.*);

  always #5 clk = ~clk;

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [DATA_W-1:0] slv_read(input addr_t a);
    // unwritten words hold a pattern of the whole address
    if (slv_mem.exists(a)) begin
      return slv_mem[a];
    end
    return {a, ~a};
  endfunction

  // ----------------------------------------
  // fifo, slave and consumer models
  // ----------------------------------------
  always @(posedge clk) begin
    if (!srst_reg) begin
      if (cmd_rreq_o) begin
        if (cq_wr.size() == 0) begin
          errors++;
          $display("command fifo popped while empty at %0t", $time);
        end else begin
          pop_cnt++;
          if (!cq_wr[0]) begin
            check(32'(used_model + int'(cq_burst[0]) <= CPL_DEPTH), 1, "read credit at pop");
            used_model += int'(cq_burst[0]);
          end
          void'(cq_wr.pop_front());
          void'(cq_addr.pop_front());
          void'(cq_burst.pop_front());
          void'(cq_be.pop_front());
        end
      end
      if (wdata_rreq_o) begin
        if (wq_data.size() == 0) begin
          errors++;
          $display("write data fifo popped while empty at %0t", $time);
        end else begin
          void'(wq_data.pop_front());
          void'(wq_be.pop_front());
        end
      end
      cmd_empty_i <= (cq_wr.size() == 0);
      if (cq_wr.size() != 0) begin
        cmd_is_wr_i <= cq_wr[0];
        cmd_addr_i  <= cq_addr[0];
        cmd_burst_i <= cq_burst[0];
        cmd_be_i    <= cq_be[0];
      end
      wdata_i <= (wq_data.size() != 0) ? wq_data[0] : '0;
      wbe_i   <= (wq_be.size() != 0) ? wq_be[0] : '0;

      // write beats against the expected queue
      if (avm_write_o) begin
        if (ew_addr.size() == 0) begin
          errors++;
          $display("unexpected avalon write beat at %0t", $time);
        end else begin
          check(avm_address_o, ew_addr[0], "write address");
          check(avm_burstcount_o, ew_burst[0], "write burst");
          check(avm_writedata_o, ew_data[0], "write data");
          check(avm_byteenable_o, ew_be[0], "write byte enable");
          slv_mem[ew_addr[0] + addr_t'(ew_idx[0])] = avm_writedata_o;
          void'(ew_addr.pop_front());
          void'(ew_burst.pop_front());
          void'(ew_data.pop_front());
          void'(ew_be.pop_front());
          void'(ew_idx.pop_front());
        end
      end
      if (avm_read_o) begin
        if (er_addr.size() == 0) begin
          errors++;
          $display("unexpected avalon read at %0t", $time);
        end else begin
          check(avm_address_o, er_addr[0], "read address");
          check(avm_burstcount_o, er_burst[0], "read burst");
          check(avm_byteenable_o, er_be[0], "read byte enable");
          sp_addr.push_back(avm_address_o);
          sp_burst.push_back(avm_burstcount_o);
          sp_due.push_back(cyc + 2 + int'($unsigned($random(seed)) % 4));
          void'(er_addr.pop_front());
          void'(er_burst.pop_front());
          void'(er_be.pop_front());
        end
      end

      // slave returns one burst at a time in issue order
      if (sl_left == 0 && sp_addr.size() != 0 && cyc >= sp_due[0]) begin
        sl_addr = sp_addr.pop_front();
        sl_left = int'(sp_burst.pop_front());
        void'(sp_due.pop_front());
        sl_idx  = 0;
        sl_err  = (sl_addr >= 32'h100) && (sl_addr < 32'h140);
      end
      if (sl_left > 0) begin
        avm_readdatavalid_i <= 1'b1;
        avm_readdata_i      <= slv_read(sl_addr + addr_t'(sl_idx));
        avm_response_i      <= sl_err ? 2'b10 : 2'b00;
        rc_data.push_back(slv_read(sl_addr + addr_t'(sl_idx)));
        rc_err.push_back(sl_err);
        sl_idx++;
        sl_left--;
      end else begin
        avm_readdatavalid_i <= 1'b0;
        avm_readdata_i      <= '0;
        avm_response_i      <= 2'b00;
      end
      avm_waitrequest_i <= !wdata_rreq_o && (($random(seed) & 3) == 0);

      // completion consumer
      if (chk_pend) begin
        if (cpl_err_o && cpl_rdata_o == '0 && blk_exp > 0 &&
            !(rc_data.size() != 0 && rc_data[0] == '0 && rc_err[0])) begin
          blk_exp--;
          checks++;
        end else if (rc_data.size() == 0) begin
          errors++;
          $display("completion read with no entry predicted at %0t", $time);
        end else begin
          check(cpl_rdata_o, rc_data.pop_front(), "completion data");
          check(cpl_err_o, rc_err.pop_front(), "completion error flag");
        end
      end
      chk_pend = cpl_rdreq_i;
      if (cpl_valid_o) begin
        stored++;
      end
      if (drain && stored > 0) begin
        cpl_rdreq_i <= 1'b1;
        stored--;
        used_model--;
      end else begin
        cpl_rdreq_i <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cyc++;
    if (cyc >= MAX_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic apb_xfer(input logic wr, input apb_addr_t a, input reg_t d,
                          output reg_t rd, output logic err);
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= a;
    pwdata_i  <= d;
    @(posedge clk);
    penable_i <= 1'b1;
    @(posedge clk);
    rd = prdata_o;
    err = pslverr_o;
    check(pready_o, 1'b1, "pready in access phase");
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic reg_write(input apb_addr_t a, input reg_t d);
    reg_t rd;
    logic err;
    apb_xfer(1'b1, a, d, rd, err);
    if (a == REG_WINDOW) begin
      win = int'(d[4:0]);
    end
  endtask

  task automatic reg_expect(input apb_addr_t a, input reg_t exp, input string what);
    reg_t rd;
    logic err;
    apb_xfer(1'b0, a, '0, rd, err);
    check(rd, exp, what);
    check(err, 1'b0, "pslverr on known offset");
  endtask

  task automatic push_cmd(input bit is_wr, input addr_t a, input burst_t b);
    bit blocked;
    logic [DATA_W-1:0] d;
    logic [BE_W-1:0] be;
    // blocked when the address reaches past the window size
    blocked = 64'(a) >= (64'd1 << win);
    be = $random(seed);
    cq_wr.push_back(is_wr);
    cq_addr.push_back(a);
    cq_burst.push_back(b);
    cq_be.push_back(be);
    if (blocked) begin
      blocked_model++;
    end
    if (is_wr) begin
      for (int i = 0; i < int'(b); i++) begin
        d = {$random(seed), $random(seed)};
        be = $random(seed);
        wq_data.push_back(d);
        wq_be.push_back(be);
        if (!blocked) begin
          ew_addr.push_back(a);
          ew_burst.push_back(b);
          ew_data.push_back(d);
          ew_be.push_back(be);
          ew_idx.push_back(i);
        end
      end
    end else if (blocked) begin
      blk_exp += int'(b);
    end else begin
      er_addr.push_back(a);
      er_burst.push_back(b);
      er_be.push_back(be);
    end
  endtask

  function automatic burst_t rand_burst();
    return burst_t'(1 + ($unsigned($random(seed)) % 8));
  endfunction

  task automatic wait_done();
    while (cq_wr.size() != 0 || wq_data.size() != 0 || ew_addr.size() != 0 ||
           er_addr.size() != 0 || sp_addr.size() != 0 || sl_left != 0 ||
           rc_data.size() != 0 || blk_exp != 0 || stored != 0 || chk_pend) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - test_errs);
    test_errs = errors;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    reg_t rd;
    logic err;
    srst_reg = 1'b1;
    {psel_i, penable_i, pwrite_i, paddr_i, pwdata_i} = '0;
    {cmd_empty_i, cmd_is_wr_i, cmd_addr_i, cmd_burst_i, cmd_be_i} = {1'b1, 37'd0, 8'd0};
    {wdata_i, wbe_i, avm_waitrequest_i, avm_readdata_i} = '0;
    {avm_readdatavalid_i, avm_response_i, cpl_rdreq_i} = '0;
    repeat (16) @(posedge clk);
    srst_reg <= 1'b0;

    reg_expect(REG_CTRL, 0, "ctrl reset");
    reg_expect(REG_WINDOW, 16, "window reset");
    reg_expect(REG_BLOCKED, 0, "blocked reset");
    reg_expect(REG_CPL_USED, 0, "used reset");
    reg_write(REG_WINDOW, 12);
    reg_expect(REG_WINDOW, 12, "window readback");
    reg_write(REG_CTRL, 1);
    reg_expect(REG_CTRL, 1, "ctrl readback");
    reg_write(REG_CTRL, 0);
    reg_write(REG_WINDOW, 16);
    apb_xfer(1'b0, 8'h10, '0, rd, err);
    check(err, 1'b1, "pslverr on unknown offset");
    push_cmd(1'b1, 32'h20, 4);
    push_cmd(1'b1, 32'h37, 2);
    repeat (30) @(posedge clk);
    check(pop_cnt, 0, "pops while disabled");
    end_test(1, "register access");

    reg_write(REG_CTRL, 1);
    for (int i = 0; i < 10; i++) begin
      push_cmd(1'b1, 32'h1000 + 32'(i * 16), rand_burst());
    end
    wait_done();
    end_test(2, "in-window writes");

    for (int i = 0; i < 6; i++) begin
      push_cmd(1'b0, 32'h1000 + 32'(i * 8), rand_burst());
      push_cmd(1'b0, 32'h120 + 32'(i), rand_burst());
    end
    wait_done();
    end_test(3, "in-window reads");

    reg_write(REG_WINDOW, 10);
    blocked_model = 0;
    for (int i = 0; i < 8; i++) begin
      push_cmd(i[0], (i < 5) ? 32'h400 + 32'(i * 64) : 32'(i * 16), rand_burst());
    end
    wait_done();
    reg_expect(REG_BLOCKED, reg_t'(blocked_model), "blocked count");
    reg_write(REG_BLOCKED, 0);
    reg_expect(REG_BLOCKED, 0, "blocked cleared");
    end_test(4, "window blocking");

    drain = 1'b0;
    for (int i = 0; i < 6; i++) begin
      push_cmd(1'b0, 32'h40 + 32'(i * 8), 8);
    end
    for (int i = 0; i < 10; i++) begin
      apb_xfer(1'b0, REG_CPL_USED, '0, rd, err);
      check(32'(rd <= CPL_DEPTH), 1, "used level within depth");
    end
    drain = 1'b1;
    wait_done();
    reg_expect(REG_CPL_USED, 0, "used after drain");
    end_test(5, "credit limit");

    blocked_model = 0;
    for (int i = 0; i < 200; i++) begin
      push_cmd($random(seed) & 1, (($random(seed) & 3) == 0) ? $random(seed) | 32'h400
               : $random(seed) & 32'h3ff, rand_burst());
    end
    wait_done();
    reg_expect(REG_BLOCKED, reg_t'(blocked_model), "blocked count after mixed traffic");
    reg_expect(REG_CPL_USED, 0, "used after mixed traffic");
    end_test(6, "mixed random traffic");

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb.f */
src/bam_pkg.sv
src/bam_csr.sv
src/bam_cmd_ctrl.sv
src/bam_cpl_buffer.sv
src/bam_top.sv
test/bam_assertions.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_top -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  exit 1
fi
